// File: vec_pkg.sv
// Lane constants and types; the lane is fixed at 64 bits wide, so LANE_BYTES stays at 8
package vec_pkg;

    // Width of one operand or result word
    localparam int unsigned LANE_BYTES = 8;
    localparam int unsigned BYTE_IDX_W = $clog2(LANE_BYTES);

    // Issue to result in cycles, one per pipeline register
    localparam int unsigned PIPE_LATENCY = 2;

    typedef logic [63:0]             bus64_t;
    typedef logic [1:0]              sew_t;
    typedef logic [2:0]              vec_instr_t;
    typedef logic [BYTE_IDX_W-1:0]   byte_idx_t;

    // Element width codes
    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;
    localparam sew_t SEW_64 = 2'd3;

    // Operation codes, 6 and 7 are unused and give zero
    localparam vec_instr_t VADD   = 3'd0;
    localparam vec_instr_t VSUB   = 3'd1;
    localparam vec_instr_t VSADDU = 3'd2;
    localparam vec_instr_t VSADD  = 3'd3;
    localparam vec_instr_t VSSUBU = 3'd4;
    localparam vec_instr_t VSSUB  = 3'd5;

    // Low byte-index bits that address a byte inside one element.
    // A byte whose index has these bits clear starts a new element
    function automatic byte_idx_t sew_byte_mask(sew_t sew);
        byte_idx_t mask;
        case (sew)
            SEW_8:   mask = byte_idx_t'(0);
            SEW_16:  mask = byte_idx_t'(1);
            SEW_32:  mask = byte_idx_t'(3);
            default: mask = byte_idx_t'(7);
        endcase
        return mask;
    endfunction

endpackage

// File: vec_op_if.sv
// One registered operation per cycle; no handshake, valid qualifies the other fields
`timescale 1ns/100ps

interface vec_op_if
    import vec_pkg::*;
();

    logic       valid;
    vec_instr_t instr;
    sew_t       sew;
    bus64_t     vs1;
    bus64_t     vs2;

    // Operand register drives everything
    modport producer (output valid, output instr, output sew, output vs1, output vs2);

    // Arithmetic blocks only look at the payload
    modport consumer (input instr, input sew, input vs1, input vs2);

    // Result stage needs the strobe and the code to pick a result
    modport select (input valid, input instr);

endinterface

// File: vec_operand_stage.sv
// First pipeline register; payload holds its last value while valid_i is low
`timescale 1ns/100ps

module vec_operand_stage
    import vec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       valid_i,
    input  vec_instr_t instr_i,
    input  sew_t       sew_i,
    input  bus64_t     vs1_i,
    input  bus64_t     vs2_i,
    vec_op_if.producer op_o
);

    // Strobe follows the issue every cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_o.valid <= 1'b0;
        end else begin
            op_o.valid <= valid_i;
        end
    end

    // Only load on an issue so idle cycles do not toggle the wide operand flops
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o.instr <= instr_i;
            op_o.sew   <= sew_i;
            op_o.vs1   <= vs1_i;
            op_o.vs2   <= vs2_i;
        end
    end

endmodule

// File: vaddsub.sv
// Wrapping packed add and subtract, combinational; any code other than VSUB adds
`timescale 1ns/100ps

module vaddsub
    import vec_pkg::*;
(
    vec_op_if.consumer op_i,
    output bus64_t     result_o
);

    logic                           is_sub;
    byte_idx_t                      mask;
    logic [LANE_BYTES-1:0][7:0]     data_a;
    logic [LANE_BYTES-1:0][7:0]     data_b;
    logic [LANE_BYTES-1:0][7:0]     sum;
    logic [LANE_BYTES-1:0]          carry_in;
    // chain[i] is the carry out of byte i-1, bit 0 is never selected
    logic [LANE_BYTES:0]            chain;

    assign is_sub = (op_i.instr == VSUB);
    assign mask   = sew_byte_mask(op_i.sew);

    always_comb begin
        chain[0] = 1'b0;
        for (int i = 0; i < LANE_BYTES; i++) begin
            data_a[i] = op_i.vs1[i*8 +: 8];
            // Subtract as vs1 + ~vs2 + 1 per element
            data_b[i] = is_sub ? ~op_i.vs2[i*8 +: 8] : op_i.vs2[i*8 +: 8];

            // The chain is cut where a new element begins
            if ((byte_idx_t'(i) & mask) == '0) begin
                carry_in[i] = is_sub;
            end else begin
                carry_in[i] = chain[i];
            end

            {chain[i+1], sum[i]} = {1'b0, data_a[i]} + {1'b0, data_b[i]}
                                 + {8'd0, carry_in[i]};
        end
    end

    // Carry out of each element top is simply dropped, which gives the wrap
    assign result_o = bus64_t'(sum);

endmodule

// File: vsaddsub.sv
// Saturating packed add and subtract, combinational; codes other than the four saturating ones give zero
`timescale 1ns/100ps

module vsaddsub
    import vec_pkg::*;
(
    vec_op_if.consumer op_i,
    output bus64_t     result_o
);

    logic                           is_saddu;
    logic                           is_sadd;
    logic                           is_ssubu;
    logic                           is_ssub;
    logic                           is_sub;
    logic                           is_sat;
    byte_idx_t                      mask;

    logic [LANE_BYTES-1:0][7:0]     data_a;
    logic [LANE_BYTES-1:0][7:0]     data_b;
    logic [LANE_BYTES-1:0][7:0]     sum;
    logic [LANE_BYTES-1:0]          carry_in;
    logic [LANE_BYTES:0]            chain;

    // Overflow as if each byte were the top of its element
    logic [LANE_BYTES-1:0]          overflow;
    // Index of the top byte of the element each byte belongs to
    byte_idx_t [LANE_BYTES-1:0]     top_idx;
    logic [LANE_BYTES-1:0][7:0]     clamp;
    logic [LANE_BYTES-1:0][7:0]     sat_bytes;

    assign is_saddu = (op_i.instr == VSADDU);
    assign is_sadd  = (op_i.instr == VSADD);
    assign is_ssubu = (op_i.instr == VSSUBU);
    assign is_ssub  = (op_i.instr == VSSUB);
    assign is_sub   = is_ssubu | is_ssub;
    assign is_sat   = is_saddu | is_sadd | is_sub;

    assign mask = sew_byte_mask(op_i.sew);

    // Segmented byte adders, same cut rule as the wrapping block
    always_comb begin
        chain[0] = 1'b0;
        for (int i = 0; i < LANE_BYTES; i++) begin
            data_a[i] = op_i.vs1[i*8 +: 8];
            data_b[i] = is_sub ? ~op_i.vs2[i*8 +: 8] : op_i.vs2[i*8 +: 8];

            if ((byte_idx_t'(i) & mask) == '0) begin
                carry_in[i] = is_sub;
            end else begin
                carry_in[i] = chain[i];
            end

            {chain[i+1], sum[i]} = {1'b0, data_a[i]} + {1'b0, data_b[i]}
                                 + {8'd0, carry_in[i]};
        end
    end

    always_comb begin
        for (int i = 0; i < LANE_BYTES; i++) begin
            if (is_saddu) begin
                // Unsigned add saturates on carry out of the element
                overflow[i] = chain[i+1];
            end else if (is_ssubu) begin
                // No carry out of a + ~b + 1 means a borrow
                overflow[i] = ~chain[i+1];
            end else if (is_sadd || is_ssub) begin
                // With b already inverted for subtract, both signed cases reduce
                // to equal operand signs and a result sign that differs
                overflow[i] = (data_a[i][7] ~^ data_b[i][7]) & (data_a[i][7] ^ sum[i][7]);
            end else begin
                overflow[i] = 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LANE_BYTES; i++) begin
            top_idx[i] = byte_idx_t'(i) | mask;

            if (is_saddu) begin
                clamp[i] = 8'hFF;
            end else if (is_ssubu) begin
                clamp[i] = 8'h00;
            end else if (top_idx[i] == byte_idx_t'(i)) begin
                // Signed overflow always goes toward the sign of vs1
                clamp[i] = data_a[top_idx[i]][7] ? 8'h80 : 8'h7F;
            end else begin
                clamp[i] = data_a[top_idx[i]][7] ? 8'h00 : 8'hFF;
            end

            // The whole element follows the decision taken at its top byte
            if (!is_sat) begin
                sat_bytes[i] = 8'h00;
            end else if (overflow[top_idx[i]]) begin
                sat_bytes[i] = clamp[i];
            end else begin
                sat_bytes[i] = sum[i];
            end
        end
    end

    assign result_o = bus64_t'(sat_bytes);

endmodule

// File: vec_result_stage.sv
// Second pipeline register; result_o holds the last loaded value while valid_o is low
`timescale 1ns/100ps

module vec_result_stage
    import vec_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    vec_op_if.select op_i,
    input  bus64_t   wrap_i,
    input  bus64_t   sat_i,
    output bus64_t   result_o,
    output logic     valid_o
);

    bus64_t result_d;
    bus64_t result_q;
    logic   valid_q;

    always_comb begin
        case (op_i.instr)
            VADD, VSUB: begin
                result_d = wrap_i;
            end
            VSADDU, VSADD, VSSUBU, VSSUB: begin
                result_d = sat_i;
            end
            default: begin
                result_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= op_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_i.valid) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;
    assign valid_o  = valid_q;

endmodule

// File: vec_alu_top.sv
// One 64-bit vector integer lane; result comes PIPE_LATENCY (2) cycles after issue, no back-pressure
`timescale 1ns/100ps

module vec_alu_top
    import vec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       valid_i,
    input  vec_instr_t instr_i,
    input  sew_t       sew_i,
    input  bus64_t     vs1_i,
    input  bus64_t     vs2_i,
    output bus64_t     result_o,
    output logic       valid_o
);

    bus64_t wrap_result;
    bus64_t sat_result;

    // Registered operation shared by both arithmetic blocks and the result stage
    vec_op_if op_bus ();

    // Cycle 1 captures the issue
    vec_operand_stage u_operand_stage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .instr_i (instr_i),
        .sew_i   (sew_i),
        .vs1_i   (vs1_i),
        .vs2_i   (vs2_i),
        .op_o    (op_bus.producer)
    );

    vaddsub u_vaddsub (
        .op_i     (op_bus.consumer),
        .result_o (wrap_result)
    );

    vsaddsub u_vsaddsub (
        .op_i     (op_bus.consumer),
        .result_o (sat_result)
    );

    // Cycle 2 picks and registers the result
    vec_result_stage u_result_stage (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .op_i     (op_bus.select),
        .wrap_i   (wrap_result),
        .sat_i    (sat_result),
        .result_o (result_o),
        .valid_o  (valid_o)
    );

endmodule

// File: tb_vec_alu.sv
// Self-checking testbench for the 64-bit lane; assumes a fixed 2-cycle latency and no back-pressure
`timescale 1ns/100ps

module tb_vec_alu
    import vec_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int DIRECTED_OPS    = 44;
    localparam int RANDOM_OPS      = 400;
    // Random idle cycles can at most double the issue time
    localparam int WATCHDOG_CYCLES = 2 * (DIRECTED_OPS + RANDOM_OPS) + 100;

    logic       clk;
    logic       rst;
    logic       valid;
    vec_instr_t instr;
    sew_t       sew;
    bus64_t     vs1;
    bus64_t     vs2;
    bus64_t     result;
    logic       result_valid;

    bus64_t      exp_q[$];
    int          due_q[$];
    int          cycle_cnt   = 0;
    logic [31:0] lfsr_state  = 32'h8c43;

    vec_alu_top u_dut (
        .clk_i    (clk),
        .rst_i    (rst),
        .valid_i  (valid),
        .instr_i  (instr),
        .sew_i    (sew),
        .vs1_i    (vs1),
        .vs2_i    (vs2),
        .result_o (result),
        .valid_o  (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic bus64_t rand_bits(int n);
        bus64_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r[i] = lfsr_state[0];
        end
        return r;
    endfunction

    // Copies the low element of v into every element of the word
    function automatic bus64_t replicate(sew_t width, bus64_t v);
        int     w;
        bus64_t m;
        bus64_t r;
        w = 8 << width;
        m = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        r = '0;
        for (int e = 0; e < 64 / w; e++) begin
            r = r | ((v & m) << (e * w));
        end
        return r;
    endfunction

    // Element by element model in wide integer arithmetic, clamped per the saturation rules
    function automatic bus64_t ref_result(vec_instr_t op, sew_t width, bus64_t a, bus64_t b);
        int                 w;
        logic [65:0]        mask;
        logic [65:0]        ua;
        logic [65:0]        ub;
        logic [65:0]        t;
        logic signed [65:0] sa;
        logic signed [65:0] sb;
        logic signed [65:0] r;
        logic signed [65:0] smax;
        logic signed [65:0] smin;
        bus64_t             res;
        w    = 8 << width;
        mask = (66'd1 << w) - 66'd1;
        smax = $signed(mask >> 1);
        smin = -smax - 66'sd1;
        res  = '0;
        for (int e = 0; e < 64 / w; e++) begin
            ua = ({2'b00, a} >> (e * w)) & mask;
            ub = ({2'b00, b} >> (e * w)) & mask;
            sa = ua[w-1] ? $signed(ua) - $signed(mask) - 66'sd1 : $signed(ua);
            sb = ub[w-1] ? $signed(ub) - $signed(mask) - 66'sd1 : $signed(ub);
            case (op)
                VADD:    r = $signed(ua + ub);
                VSUB:    r = $signed(ua - ub);
                VSADDU:  r = (ua + ub > mask) ? $signed(mask) : $signed(ua + ub);
                VSSUBU:  r = (ua < ub) ? 66'sd0 : $signed(ua - ub);
                VSADD:   r = sa + sb;
                VSSUB:   r = sa - sb;
                default: r = 66'sd0;
            endcase
            if (op == VSADD || op == VSSUB) begin
                if (r > smax) begin
                    r = smax;
                end else if (r < smin) begin
                    r = smin;
                end
            end
            t   = r;
            res = res | bus64_t'((t & mask) << (e * w));
        end
        return res;
    endfunction

    task automatic issue_op(vec_instr_t op, sew_t width, bus64_t a, bus64_t b);
        @(negedge clk);
        valid = 1'b1;
        instr = op;
        sew   = width;
        vs1   = a;
        vs2   = b;
        exp_q.push_back(ref_result(op, width, a, b));
        // The result shows at the falling edge PIPE_LATENCY cycles after the one that drives it
        due_q.push_back(cycle_cnt + PIPE_LATENCY);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(negedge clk);
            valid = 1'b0;
        end
    endtask

    initial begin : stimulus
        sew_t       s;
        vec_instr_t r_op;
        sew_t       r_sew;
        bus64_t     one;
        bus64_t     ones;
        bus64_t     vmax;
        bus64_t     vmin;
        bus64_t     r_a;
        bus64_t     r_b;
        rst   = 1'b1;
        valid = 1'b0;
        instr = '0;
        sew   = '0;
        vs1   = '0;
        vs2   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_cycles(3);

        // Directed corners at every width, issued back to back
        for (int k = 0; k < 4; k++) begin
            s    = sew_t'(k);
            one  = replicate(s, 64'd1);
            ones = replicate(s, '1);
            vmax = replicate(s, 64'h7FFF_FFFF_FFFF_FFFF >> (64 - (8 << k)));
            vmin = replicate(s, 64'h8000_0000_0000_0000 >> (64 - (8 << k)));
            issue_op(VADD, s, ones, one);
            issue_op(VSUB, s, '0, one);
            issue_op(VSADDU, s, ones, one);
            issue_op(VSADDU, s, replicate(s, 64'd3), replicate(s, 64'd5));
            issue_op(VSSUBU, s, '0, one);
            issue_op(VSSUBU, s, replicate(s, 64'd5), replicate(s, 64'd3));
            issue_op(VSADD, s, vmax, one);
            issue_op(VSSUB, s, vmin, one);
            issue_op(VSADD, s, vmax, vmin);
            issue_op(VSSUB, s, vmax, vmin);
            issue_op(VSSUB, s, vmin, vmax);
        end

        // Random codes include the unused 6 and 7
        for (int k = 0; k < RANDOM_OPS; k++) begin
            if (rand_bits(2) == 0) begin
                idle_cycles(1);
            end
            r_op  = vec_instr_t'(rand_bits(3));
            r_sew = sew_t'(rand_bits(2));
            r_a   = rand_bits(64);
            r_b   = rand_bits(64);
            issue_op(r_op, r_sew, r_a, r_b);
        end

        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(4);

        $display("*** TEST PASSED ***");
        $finish;
    end

    // Outputs are registered, so the falling edge sees them settled
    initial begin : compare
        logic   expect_valid;
        bus64_t expected;
        @(negedge rst);
        forever begin
            @(negedge clk);
            expect_valid = (due_q.size() != 0) && (due_q[0] == cycle_cnt);
            assert (result_valid === expect_valid) else
                fail_run($sformatf("Error at %0t: valid_o is %b, expected %b",
                                   $time, result_valid, expect_valid));
            if (expect_valid) begin
                expected = exp_q.pop_front();
                void'(due_q.pop_front());
                assert (result === expected) else
                    fail_run($sformatf("Error at %0t: result_o is %h, expected %h",
                                       $time, result, expected));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Timeout: the run did not finish within the expected number of cycles");
    end

endmodule

// File: build.f
vec_pkg.sv
vec_op_if.sv
vec_operand_stage.sv
vaddsub.sv
vsaddsub.sv
vec_result_stage.sv
vec_alu_top.sv
tb_vec_alu.sv

// File: Bender.yml
package:
  name: vec_alu

sources:
  - vec_pkg.sv
  - vec_op_if.sv
  - vec_operand_stage.sv
  - vaddsub.sv
  - vsaddsub.sv
  - vec_result_stage.sv
  - vec_alu_top.sv
  - target: simulation
    files:
      - tb_vec_alu.sv
